// ==== src/lcd_frame_pkg.sv ====
package lcd_frame_pkg;

    // one byte on the LCD bus
    typedef logic [7:0] lcd_byte_t;

    // picture slot and row within a picture (char * 8 + row)
    typedef logic [1:0] pic_idx_t;
    typedef logic [5:0] glyph_row_t;

    // rs low for a command, high for data
    typedef struct packed {
        logic      rs;
        lcd_byte_t data;
    } lcd_xfer_t;

    // host write of one glyph row
    typedef struct packed {
        logic       en;
        pic_idx_t   pic;
        glyph_row_t row;
        logic [4:0] data;
    } pic_wr_t;

    // host update of the two drawn pictures
    typedef struct packed {
        logic     en;
        pic_idx_t left;
        pic_idx_t right;
    } pic_sel_t;

    typedef enum logic [2:0] {
        S_SETUP,
        S_CLEAR,
        S_CGRAM_ADDR,
        S_CGRAM_ROW,
        S_DISP_ON,
        S_CURSOR,
        S_CHAR,
        S_HOLD
    } seq_state_t;

    // HD44780 style command codes
    localparam lcd_byte_t CMD_FUNC_SET   = 8'h38;
    localparam lcd_byte_t CMD_DISP_ON    = 8'h0C;
    localparam lcd_byte_t CMD_CLEAR      = 8'h01;
    localparam lcd_byte_t CMD_CGRAM_BASE = 8'h40;
    localparam lcd_byte_t CMD_DDRAM_BASE = 8'h80;
    localparam lcd_byte_t LINE2_OFFSET   = 8'h40;
    localparam lcd_byte_t RIGHT_COL      = 8'd4;

endpackage

// ==== src/picture_store.sv ====
`timescale 1ns/1ps

module picture_store
    import lcd_frame_pkg::*;
(
    input  logic       clk_16ms,
    input  logic       reset,
    input  pic_wr_t    pic_wr,
    input  pic_sel_t   pic_sel,
    input  pic_idx_t   rd_pic,
    input  glyph_row_t rd_row,
    output lcd_byte_t  rd_data,
    output pic_idx_t   left_pic,
    output pic_idx_t   right_pic
);

    // four pictures of 64 rows, five pixels per row
    logic [4:0] mem [256];

    pic_idx_t left_q;
    pic_idx_t right_q;

    always_ff @(posedge clk_16ms) begin
        if (pic_wr.en) begin
            mem[{pic_wr.pic, pic_wr.row}] <= pic_wr.data;
        end
    end

    // synchronous read, row padded up to a full bus byte
    always_ff @(posedge clk_16ms) begin
        rd_data <= {3'b000, mem[{rd_pic, rd_row}]};
    end

    // selection defaults to slots 0 and 1
    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            left_q  <= 2'd0;
            right_q <= 2'd1;
        end else if (pic_sel.en) begin
            left_q  <= pic_sel.left;
            right_q <= pic_sel.right;
        end
    end

    assign left_pic  = left_q;
    assign right_pic = right_q;

endmodule

// ==== src/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer
    import lcd_frame_pkg::*;
#(
    parameter int HOLD_CYCLES = 200
) (
    input  logic       clk_16ms,
    input  logic       reset,
    input  pic_idx_t   left_pic,
    input  pic_idx_t   right_pic,
    input  lcd_byte_t  rd_data,
    output pic_idx_t   rd_pic,
    output glyph_row_t rd_row,
    output lcd_xfer_t  xfer,
    output logic       xfer_valid,
    input  logic       xfer_ready
);

    localparam int HOLD_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;

    seq_state_t        state;
    seq_state_t        state_next;
    logic [1:0]        setup_idx;
    logic [2:0]        char_idx;
    logic [2:0]        row_idx;
    logic              parity;
    logic [HOLD_W-1:0] hold_cnt;
    pic_idx_t          cur_pic;
    logic              fire;
    logic              hold_done;
    glyph_row_t        row_ptr;
    lcd_byte_t         col_base;

    assign fire      = xfer_valid && xfer_ready;
    assign hold_done = (hold_cnt == HOLD_W'(HOLD_CYCLES - 1));
    assign row_ptr   = {char_idx, row_idx};
    assign col_base  = parity ? RIGHT_COL : 8'h00;

    // prefetch: step to the following row in the cycle the current one leaves
    assign rd_pic = cur_pic;
    assign rd_row = (state == S_CGRAM_ROW && fire) ? row_ptr + 6'd1 : row_ptr;

    always_comb begin
        state_next = state;
        unique case (state)
            S_SETUP:      if (fire && setup_idx == 2'd2) state_next = S_CLEAR;
            S_CLEAR:      if (fire) state_next = S_CGRAM_ADDR;
            S_CGRAM_ADDR: if (fire) state_next = S_CGRAM_ROW;
            S_CGRAM_ROW: begin
                if (fire && row_idx == 3'd7) begin
                    state_next = (char_idx == 3'd7) ? S_DISP_ON : S_CGRAM_ADDR;
                end
            end
            S_DISP_ON:    if (fire) state_next = S_CURSOR;
            S_CURSOR:     if (fire) state_next = S_CHAR;
            S_CHAR: begin
                if (fire) begin
                    state_next = (char_idx == 3'd7) ? S_HOLD : S_CURSOR;
                end
            end
            S_HOLD:       if (hold_done) state_next = S_CLEAR;
        endcase
    end

    // byte for the current state, held while stalled
    always_comb begin
        xfer.rs   = 1'b0;
        xfer.data = CMD_CLEAR;
        unique case (state)
            S_SETUP: begin
                case (setup_idx)
                    2'd0:    xfer.data = CMD_FUNC_SET;
                    2'd1:    xfer.data = CMD_DISP_ON;
                    default: xfer.data = CMD_CLEAR;
                endcase
            end
            S_CLEAR:      xfer.data = CMD_CLEAR;
            S_CGRAM_ADDR: xfer.data = CMD_CGRAM_BASE + {2'b00, char_idx, 3'b000};
            S_CGRAM_ROW: begin
                xfer.rs   = 1'b1;
                xfer.data = rd_data;
            end
            S_DISP_ON:    xfer.data = CMD_DISP_ON;
            S_CURSOR: begin
                // chars 4..7 go on the second line
                xfer.data = CMD_DDRAM_BASE + col_base + {6'b000000, char_idx[1:0]}
                          + (char_idx[2] ? LINE2_OFFSET : 8'h00);
            end
            S_CHAR: begin
                xfer.rs   = 1'b1;
                xfer.data = {5'b00000, char_idx};
            end
            S_HOLD:       xfer.data = CMD_CLEAR;
        endcase
    end

    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            state      <= S_SETUP;
            xfer_valid <= 1'b0;
            setup_idx  <= 2'd0;
            char_idx   <= 3'd0;
            row_idx    <= 3'd0;
            parity     <= 1'b0;
            hold_cnt   <= '0;
            cur_pic    <= 2'd0;
        end else begin
            state      <= state_next;
            xfer_valid <= (state_next != S_HOLD);
            if (fire) begin
                case (state)
                    S_SETUP: setup_idx <= setup_idx + 2'd1;
                    S_CLEAR: begin
                        // picture for this frame is fixed here
                        cur_pic  <= parity ? right_pic : left_pic;
                        char_idx <= 3'd0;
                        row_idx  <= 3'd0;
                    end
                    S_CGRAM_ADDR: row_idx <= 3'd0;
                    S_CGRAM_ROW: begin
                        row_idx <= row_idx + 3'd1;
                        if (row_idx == 3'd7) begin
                            char_idx <= char_idx + 3'd1;
                        end
                    end
                    S_DISP_ON: char_idx <= 3'd0;
                    S_CHAR: begin
                        char_idx <= char_idx + 3'd1;
                        if (char_idx == 3'd7) begin
                            parity   <= ~parity;
                            hold_cnt <= '0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            if (state == S_HOLD) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== src/credit_tx.sv ====
`timescale 1ns/1ps

module credit_tx
    import lcd_frame_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  logic      clk_16ms,
    input  logic      reset,
    input  logic      credit_return,
    input  lcd_xfer_t xfer,
    input  logic      xfer_valid,
    output logic      xfer_ready,
    output lcd_xfer_t lcd_out,
    output logic      lcd_valid
);

    localparam int CRED_W = $clog2(CREDITS + 1);

    lcd_xfer_t         fifo [2];
    logic              wr_ptr;
    logic              rd_ptr;
    logic [1:0]        count;
    logic [1:0]        count_next;
    logic [CRED_W-1:0] credits;
    logic              ready_q;
    logic              push;
    logic              pop;

    assign xfer_ready = ready_q;
    assign push       = xfer_valid && ready_q;
    // head goes out only while the driver has room for it
    assign pop        = (count != 2'd0) && (credits != '0);
    assign lcd_valid  = pop;
    assign lcd_out    = fifo[rd_ptr];
    assign count_next = count + {1'b0, push} - {1'b0, pop};

    always_ff @(posedge clk_16ms) begin
        if (push) begin
            fifo[wr_ptr] <= xfer;
        end
    end

    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count   <= 2'd0;
            ready_q <= 1'b0;
            credits <= CRED_W'(CREDITS);
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop) rd_ptr <= ~rd_ptr;
            count   <= count_next;
            ready_q <= (count_next != 2'd2);
            // spend on send, refill on return, both cancel out
            case ({pop, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== src/lcd_frame_top.sv ====
`timescale 1ns/1ps

module lcd_frame_top
    import lcd_frame_pkg::*;
#(
    parameter int CREDITS     = 4,
    parameter int HOLD_CYCLES = 200
) (
    input  logic      clk_16ms,
    input  logic      reset,
    input  pic_wr_t   pic_wr,
    input  pic_sel_t  pic_sel,
    input  logic      credit_return,
    output lcd_xfer_t lcd_out,
    output logic      lcd_valid
);

    pic_idx_t   rd_pic;
    glyph_row_t rd_row;
    lcd_byte_t  rd_data;
    pic_idx_t   left_pic;
    pic_idx_t   right_pic;
    lcd_xfer_t  xfer;
    logic       xfer_valid;
    logic       xfer_ready;

    picture_store u_picture_store (
        .clk_16ms  (clk_16ms),
        .reset     (reset),
        .pic_wr    (pic_wr),
        .pic_sel   (pic_sel),
        .rd_pic    (rd_pic),
        .rd_row    (rd_row),
        .rd_data   (rd_data),
        .left_pic  (left_pic),
        .right_pic (right_pic)
    );

    frame_sequencer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_frame_sequencer (
        .clk_16ms   (clk_16ms),
        .reset      (reset),
        .left_pic   (left_pic),
        .right_pic  (right_pic),
        .rd_data    (rd_data),
        .rd_pic     (rd_pic),
        .rd_row     (rd_row),
        .xfer       (xfer),
        .xfer_valid (xfer_valid),
        .xfer_ready (xfer_ready)
    );

    credit_tx #(
        .CREDITS (CREDITS)
    ) u_credit_tx (
        .clk_16ms      (clk_16ms),
        .reset         (reset),
        .credit_return (credit_return),
        .xfer          (xfer),
        .xfer_valid    (xfer_valid),
        .xfer_ready    (xfer_ready),
        .lcd_out       (lcd_out),
        .lcd_valid     (lcd_valid)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_16ms,
    output logic reset
);

    initial begin
        clk_16ms = 1'b0;
        forever #(PERIOD_NS / 2) clk_16ms = ~clk_16ms;
    end

    // released on a rising edge after the reset cycles
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_16ms);
        reset <= 1'b1;
    end

endmodule

// ==== verif/lcd_frame_props.sv ====
`timescale 1ns/1ps

module lcd_frame_props
    import lcd_frame_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input logic                             clk_16ms,
    input logic                             reset,
    input logic                             credit_return,
    input logic                             lcd_valid,
    input logic [$clog2(CREDITS + 1)-1:0]   credits,
    input lcd_xfer_t                        xfer,
    input logic                             xfer_valid,
    input logic                             xfer_ready
);

    localparam int CRED_W = $clog2(CREDITS + 1);
    localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(CREDITS);

    logic [CRED_W-1:0] avail;
    int                fail_count = 0;

    // credits left at the driver, counted from the bus alone
    always_ff @(posedge clk_16ms) begin
        if (!reset) begin
            avail <= CRED_MAX;
        end else begin
            avail <= avail - CRED_W'(lcd_valid) + CRED_W'(credit_return);
        end
    end

    // a send needs a credit in hand
    assert property (@(posedge clk_16ms) disable iff (!reset)
        lcd_valid |-> avail != '0)
    else begin
        fail_count++;
        $error("lcd_valid raised with no credits left");
    end

    assert property (@(posedge clk_16ms) disable iff (!reset)
        credits <= CRED_MAX)
    else begin
        fail_count++;
        $error("credit count above the driver buffer depth");
    end

    // stalled byte stays put until accepted
    assert property (@(posedge clk_16ms) disable iff (!reset)
        xfer_valid && !xfer_ready |=> $stable(xfer))
    else begin
        fail_count++;
        $error("xfer changed while stalled");
    end

endmodule

// ==== verif/tb_lcd_frame.sv ====
`timescale 1ns/1ps

module tb_lcd_frame
    import lcd_frame_pkg::*;
();

    localparam int CREDITS  = 4;
    localparam int HOLD     = 20;
    localparam int ROWS     = 4;
    localparam int WATCHDOG = ROWS * 2 * (90 * 13 + HOLD) + 500;

    typedef struct packed {
        pic_idx_t   left;
        pic_idx_t   right;
        logic [3:0] max_delay;
    } stim_row_t;

    logic       clk_16ms;
    logic       reset;
    pic_wr_t    pic_wr;
    pic_sel_t   pic_sel;
    logic       credit_return;
    lcd_xfer_t  lcd_out;
    logic       lcd_valid;
    stim_row_t  stim_table [ROWS];
    logic [4:0] pic_copy [4][64];
    lcd_xfer_t  rx_q [$];
    integer     seed = 32'h9bbc;
    int         err_count = 0;
    int         owed = 0;
    int         max_delay = 0;
    logic       fill_done = 1'b0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(8)) u_tb_clock_gen (.*);

    lcd_frame_top #(.CREDITS(CREDITS), .HOLD_CYCLES(HOLD)) u_lcd_frame_top (.*);

    bind credit_tx lcd_frame_props #(.CREDITS(CREDITS)) u_lcd_frame_props (
        .clk_16ms      (clk_16ms),
        .reset         (reset),
        .credit_return (credit_return),
        .lcd_valid     (lcd_valid),
        .credits       (credits),
        .xfer          (xfer),
        .xfer_valid    (xfer_valid),
        .xfer_ready    (xfer_ready)
    );

    // pic 0 goes first since the sequencer reads its first row before any credit returns
    task automatic fill_pictures();
        pic_wr_t w;
        int      val;
        for (int p = 0; p < 4; p++) begin
            for (int r = 0; r < 64; r++) begin
                val = $random(seed);
                w = {1'b1, p[1:0], r[5:0], val[4:0]};
                pic_copy[p][r] = val[4:0];
                pic_wr <= w;
                @(posedge clk_16ms);
            end
        end
        pic_wr <= '0;
    endtask

    task automatic expect_byte(input logic rs, input lcd_byte_t data);
        lcd_xfer_t got;
        while (rx_q.size() == 0) @(posedge clk_16ms);
        got = rx_q.pop_front();
        assert (got.rs === rs && got.data === data) else begin
            err_count++;
            $display("** Error: lcd_out.rs exp %h got %h, lcd_out.data exp %h got %h",
                     rs, got.rs, data, got.data);
        end
    endtask

    // one frame of 90 bytes with an optional selection write halfway through the glyph load
    task automatic check_frame(input int frame, input pic_idx_t pic, input logic sel_now,
                               input stim_row_t next_row);
        int col;
        col = (frame % 2 == 1) ? 4 : 0;
        expect_byte(1'b0, 8'h01);
        for (int k = 0; k < 8; k++) begin
            expect_byte(1'b0, lcd_byte_t'(64 + 8 * k));
            for (int j = 0; j < 8; j++) begin
                expect_byte(1'b1, {3'b000, pic_copy[pic][8 * k + j]});
            end
            if (sel_now && k == 4) begin
                @(posedge clk_16ms);
                pic_sel <= {1'b1, next_row.left, next_row.right};
                @(posedge clk_16ms);
                pic_sel <= '0;
            end
        end
        expect_byte(1'b0, 8'h0C);
        for (int k = 0; k < 8; k++) begin
            // chars 4..7 on the second line
            expect_byte(1'b0, lcd_byte_t'(128 + col + (k % 4) + ((k > 3) ? 64 : 0)));
            expect_byte(1'b1, lcd_byte_t'(k));
        end
    endtask

    initial begin
        stim_row_t next_row;
        int        prop_fails;
        pic_wr = '0;
        pic_sel = '0;
        // columns are left slot, right slot and max credit delay
        // first row matches the reset selection
        stim_table[0] = {2'd0, 2'd1, 4'd0};
        stim_table[1] = {2'd2, 2'd3, 4'd3};
        stim_table[2] = {2'd3, 2'd0, 4'd12};
        stim_table[3] = {2'd1, 2'd2, 4'd0};
        @(posedge clk_16ms);
        while (reset !== 1'b1) @(posedge clk_16ms);
        fill_pictures();
        fill_done <= 1'b1;
        expect_byte(1'b0, 8'h38);
        expect_byte(1'b0, 8'h0C);
        expect_byte(1'b0, 8'h01);
        for (int r = 0; r < ROWS; r++) begin
            max_delay <= stim_table[r].max_delay;
            next_row = (r + 1 < ROWS) ? stim_table[r + 1] : stim_table[r];
            check_frame(2 * r, stim_table[r].left, 1'b0, next_row);
            check_frame(2 * r + 1, stim_table[r].right, r + 1 < ROWS, next_row);
        end
        prop_fails = u_lcd_frame_top.u_credit_tx.u_lcd_frame_props.fail_count;
        $display("run finished with %0d check error(s) and %0d assertion failure(s)",
                 err_count, prop_fails);
        if (err_count == 0 && prop_fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // downstream driver takes the sampled byte on the next edge
    always @(negedge clk_16ms) begin
        if (reset === 1'b1 && lcd_valid === 1'b1) begin
            rx_q.push_back(lcd_out);
            owed = owed + 1;
            assert (owed <= CREDITS) else begin
                err_count++;
                $display("more bytes outstanding at the LCD driver than it has credits for");
            end
        end
    end

    // one credit back per consumed byte after a random delay
    initial begin
        int delay;
        credit_return = 1'b0;
        forever begin
            @(posedge clk_16ms);
            credit_return <= 1'b0;
            if (fill_done && owed > 0) begin
                delay = $unsigned($random(seed)) % (max_delay + 1);
                repeat (delay) @(posedge clk_16ms);
                credit_return <= 1'b1;
                owed = owed - 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk_16ms);
        $display("timeout, the frames did not complete within %0d cycles", WATCHDOG);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== lcd_frame.f ====
src/lcd_frame_pkg.sv
src/picture_store.sv
src/frame_sequencer.sv
src/credit_tx.sv
src/lcd_frame_top.sv
verif/tb_clock_gen.sv
verif/lcd_frame_props.sv
verif/tb_lcd_frame.sv

// ==== Bender.yml ====
package:
  name: lcd_frame

sources:
  - files:
      - src/lcd_frame_pkg.sv
      - src/picture_store.sv
      - src/frame_sequencer.sv
      - src/credit_tx.sv
      - src/lcd_frame_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/lcd_frame_props.sv
      - verif/tb_lcd_frame.sv
